//--- hdl/fp_add_cfg.svh
`ifndef FP_ADD_CFG_SVH
`define FP_ADD_CFG_SVH

//////////////////////////////////////////////////
// IEEE 754 single precision field layout
//////////////////////////////////////////////////

`define FP_EXP_W 8    // Biased exponent field
`define FP_FRAC_W 23  // Stored fraction field

// Hidden bit, 23 fraction bits, guard, round, two sticky
`define FP_MANT_W 28

`define FP_BIAS 127

// Quiet NaN returned for every invalid case
`define FP_QNAN 32'h7FC0_0000

`endif

//--- hdl/fp_add_pkg.sv
package fp_add_pkg;

  `include "fp_add_cfg.svh"

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////
  typedef logic [`FP_EXP_W+`FP_FRAC_W:0] fp_word_t;   // Raw IEEE word
  typedef logic [`FP_EXP_W-1:0] fp_exp_t;              // Biased exponent
  typedef logic signed [`FP_EXP_W+1:0] fp_exp_wide_t;  // Working exponent
  typedef logic [`FP_MANT_W-1:0] fp_mant_t;            // Extended mantissa
  typedef logic [`FP_MANT_W:0] fp_sum_t;               // Mantissa sum with carry

  // Operand class codes
  typedef enum logic [2:0] {
    ZERO = 3'b000,
    SUB  = 3'b001,
    INF  = 3'b010,
    NAN  = 3'b011,
    NORM = 3'b100
  } fp_class_e;

  //////////////////////////////////////////////////
  // Stage records
  //////////////////////////////////////////////////
  typedef struct packed {
    logic      sign;
    fp_class_e cls;
    fp_exp_t   exp;    // Subnormals and zero carry 1 here
    fp_mant_t  mant;
  } fp_unpacked_s;

  typedef struct packed {
    logic     big_sign;
    logic     small_sign;
    fp_exp_t  exp;         // Common exponent of the pair
    fp_mant_t big_mant;
    fp_mant_t small_mant;  // Already aligned, sticky in bit 0
    logic     any_nan;
    logic     big_inf;
    logic     both_inf_opp;
  } fp_aligned_s;

  typedef struct packed {
    logic         sign;
    fp_exp_wide_t exp;
    fp_mant_t     mant;
    logic         zero;    // Exact zero sum
    logic         any_nan;
    logic         big_inf;
    logic         both_inf_opp;
  } fp_norm_s;

endpackage

//--- hdl/fp_classify.sv
`include "fp_add_cfg.svh"

module fp_classify (
  input  fp_add_pkg::fp_word_t     word,
  output fp_add_pkg::fp_unpacked_s op
);

  fp_add_pkg::fp_exp_t    exp_f;
  logic [`FP_FRAC_W-1:0]  frac_f;
  logic                   exp_ones;
  logic                   exp_zero;
  logic                   frac_zero;

  assign exp_f     = word[`FP_EXP_W+`FP_FRAC_W-1:`FP_FRAC_W];
  assign frac_f    = word[`FP_FRAC_W-1:0];
  assign exp_ones  = &exp_f;
  assign exp_zero  = ~|exp_f;
  assign frac_zero = ~|frac_f;

  always_comb begin
    op.sign = word[`FP_EXP_W+`FP_FRAC_W];

    if (exp_ones) begin
      op.cls = frac_zero ? fp_add_pkg::INF : fp_add_pkg::NAN;
    end else if (exp_zero) begin
      op.cls = frac_zero ? fp_add_pkg::ZERO : fp_add_pkg::SUB;
    end else begin
      op.cls = fp_add_pkg::NORM;
    end

    // Zero and subnormal share the scale of exponent 1
    op.exp = exp_zero ? fp_add_pkg::fp_exp_t'(1) : exp_f;

    // Hidden bit only for normal numbers
    op.mant = {~exp_zero & ~exp_ones, frac_f, 4'b0000};
  end

endmodule

//--- hdl/fp_preadder.sv
`include "fp_add_cfg.svh"

module fp_preadder (
  input  fp_add_pkg::fp_unpacked_s a_op,
  input  fp_add_pkg::fp_unpacked_s b_op,
  output fp_add_pkg::fp_aligned_s  aligned
);

  //////////////////////////////////////////////////
  // Magnitude ordering
  //////////////////////////////////////////////////
  logic                     exp_a_gt;
  logic                     exp_equal;
  logic                     mant_a_ge;
  logic                     a_is_big;
  fp_add_pkg::fp_unpacked_s big_op;
  fp_add_pkg::fp_unpacked_s small_op;

  assign exp_a_gt  = a_op.exp > b_op.exp;
  assign exp_equal = a_op.exp == b_op.exp;
  assign mant_a_ge = a_op.mant >= b_op.mant;

  // Ties go to a, the sum is the same either way
  assign a_is_big = exp_a_gt || (exp_equal && mant_a_ge);

  assign big_op   = a_is_big ? a_op : b_op;
  assign small_op = a_is_big ? b_op : a_op;

  //////////////////////////////////////////////////
  // Alignment of the smaller mantissa
  //////////////////////////////////////////////////
  fp_add_pkg::fp_exp_t  exp_diff;
  logic [4:0]           shift_amt;
  fp_add_pkg::fp_mant_t shifted;
  fp_add_pkg::fp_mant_t lost_mask;
  logic                 sticky;

  assign exp_diff = big_op.exp - small_op.exp;  // Never negative after the swap

  // Past the mantissa width everything lands in sticky
  assign shift_amt = (exp_diff > `FP_MANT_W) ? 5'(`FP_MANT_W) : exp_diff[4:0];

  assign shifted   = small_op.mant >> shift_amt;
  assign lost_mask = ~(fp_add_pkg::fp_mant_t'('1) << shift_amt);
  assign sticky    = |(small_op.mant & lost_mask);

  //////////////////////////////////////////////////
  // Special class flags
  //////////////////////////////////////////////////
  logic a_nan;
  logic b_nan;
  logic a_inf;
  logic b_inf;

  assign a_nan = a_op.cls == fp_add_pkg::NAN;
  assign b_nan = b_op.cls == fp_add_pkg::NAN;
  assign a_inf = a_op.cls == fp_add_pkg::INF;
  assign b_inf = b_op.cls == fp_add_pkg::INF;

  //////////////////////////////////////////////////
  // Output record
  //////////////////////////////////////////////////
  always_comb begin
    aligned.big_sign   = big_op.sign;
    aligned.small_sign = small_op.sign;
    aligned.exp        = big_op.exp;
    aligned.big_mant   = big_op.mant;

    // Sticky folds into the lowest bit
    aligned.small_mant = {shifted[`FP_MANT_W-1:1], shifted[0] | sticky};

    aligned.any_nan = a_nan | b_nan;

    // Infinity has the top exponent so it always ends up as big
    aligned.big_inf = big_op.cls == fp_add_pkg::INF;

    aligned.both_inf_opp = a_inf & b_inf & (a_op.sign ^ b_op.sign);
  end

endmodule

//--- hdl/fp_mant_adder.sv
`include "fp_add_cfg.svh"

module fp_mant_adder (
  input  fp_add_pkg::fp_aligned_s aligned,
  output fp_add_pkg::fp_norm_s    norm
);

  logic                     eff_sub;
  fp_add_pkg::fp_sum_t      raw_sum;
  logic                     carry;
  logic                     sum_zero;
  fp_add_pkg::fp_exp_wide_t exp_in;

  assign eff_sub = aligned.big_sign ^ aligned.small_sign;

  // Big is at least small, so the difference stays non-negative
  assign raw_sum = eff_sub ?
                   {1'b0, aligned.big_mant} - {1'b0, aligned.small_mant} :
                   {1'b0, aligned.big_mant} + {1'b0, aligned.small_mant};

  assign carry    = raw_sum[`FP_MANT_W];
  assign sum_zero = ~|raw_sum;
  assign exp_in   = fp_add_pkg::fp_exp_wide_t'(aligned.exp);

  //////////////////////////////////////////////////
  // Leading zero count and shift limit
  //////////////////////////////////////////////////
  logic [4:0]          lzc;
  fp_add_pkg::fp_exp_t shift_lim;
  logic [4:0]          norm_shift;

  always_comb begin
    lzc = 5'(`FP_MANT_W);  // All zero
    for (int i = 0; i < `FP_MANT_W; i++) begin
      if (raw_sum[i]) lzc = 5'(`FP_MANT_W - 1 - i);
    end
  end

  // Exponent may not drop below 1, the rest stays subnormal
  assign shift_lim  = aligned.exp - fp_add_pkg::fp_exp_t'(1);
  assign norm_shift = (lzc > shift_lim) ? shift_lim[4:0] : lzc;

  //////////////////////////////////////////////////
  // Normalized result
  //////////////////////////////////////////////////
  always_comb begin
    norm.any_nan      = aligned.any_nan;
    norm.big_inf      = aligned.big_inf;
    norm.both_inf_opp = aligned.both_inf_opp;
    norm.zero         = sum_zero;

    // Exact cancellation gives +0, infinity keeps its own sign
    norm.sign = (sum_zero & eff_sub & ~aligned.big_inf) ? 1'b0 : aligned.big_sign;

    if (carry) begin
      norm.mant = {raw_sum[`FP_MANT_W:2], raw_sum[1] | raw_sum[0]};  // Keep sticky
      norm.exp  = exp_in + 10'sd1;
    end else begin
      norm.mant = raw_sum[`FP_MANT_W-1:0] << norm_shift;
      norm.exp  = exp_in - fp_add_pkg::fp_exp_wide_t'(norm_shift);
    end
  end

endmodule

//--- hdl/fp_round_pack.sv
`include "fp_add_cfg.svh"

module fp_round_pack (
  input  fp_add_pkg::fp_norm_s norm,
  output fp_add_pkg::fp_word_t result
);

  localparam int KEEP_W  = `FP_MANT_W - 4;   // Hidden bit plus fraction
  localparam int EXP_MAX = 2 * `FP_BIAS + 1; // All-ones exponent

  //////////////////////////////////////////////////
  // Round to nearest even
  //////////////////////////////////////////////////
  logic                     lsb;
  logic                     guard;
  logic                     rest;
  logic                     round_up;
  logic [KEEP_W:0]          rounded;
  logic [KEEP_W-1:0]        kept;
  fp_add_pkg::fp_exp_wide_t exp_r;
  fp_add_pkg::fp_exp_t      pack_exp;

  assign lsb      = norm.mant[4];
  assign guard    = norm.mant[3];
  assign rest     = |norm.mant[2:0];
  assign round_up = guard & (rest | lsb);  // Ties go to even

  assign rounded = {1'b0, norm.mant[`FP_MANT_W-1:4]} + (KEEP_W + 1)'(round_up);

  // Carry out of rounding leaves 1.000..., shift and bump exponent
  assign kept  = rounded[KEEP_W] ? rounded[KEEP_W:1] : rounded[KEEP_W-1:0];
  assign exp_r = norm.exp + fp_add_pkg::fp_exp_wide_t'(rounded[KEEP_W]);

  // No hidden bit at exponent 1 packs as subnormal
  assign pack_exp = kept[KEEP_W-1] ? exp_r[`FP_EXP_W-1:0] : '0;

  //////////////////////////////////////////////////
  // Special cases and packing
  //////////////////////////////////////////////////
  logic [`FP_EXP_W+`FP_FRAC_W-1:0] inf_mag;

  assign inf_mag = {{`FP_EXP_W{1'b1}}, {`FP_FRAC_W{1'b0}}};

  always_comb begin
    if (norm.any_nan || norm.both_inf_opp) begin
      result = `FP_QNAN;
    end else if (norm.big_inf) begin
      result = {norm.sign, inf_mag};
    end else if (norm.zero) begin
      // Sign already reduced to the AND of the operand signs
      result = {norm.sign, {(`FP_EXP_W + `FP_FRAC_W){1'b0}}};
    end else if (exp_r >= EXP_MAX) begin
      result = {norm.sign, inf_mag};  // Overflow
    end else begin
      result = {norm.sign, pack_exp, kept[`FP_FRAC_W-1:0]};
    end
  end

endmodule

//--- hdl/fp_add_top.sv
module fp_add_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  input  fp_add_pkg::fp_word_t a,
  input  fp_add_pkg::fp_word_t b,
  output logic                 out_valid,
  output fp_add_pkg::fp_word_t sum
);

  fp_add_pkg::fp_unpacked_s a_op;
  fp_add_pkg::fp_unpacked_s b_op;
  fp_add_pkg::fp_aligned_s  aligned;
  fp_add_pkg::fp_aligned_s  s1_aligned;  // Stage 1 register
  fp_add_pkg::fp_norm_s     norm;
  fp_add_pkg::fp_norm_s     s2_norm;     // Stage 2 register
  fp_add_pkg::fp_word_t     result;
  logic [2:0]               valid_q;

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////
  fp_classify u_class_a (.word(a), .op(a_op));
  fp_classify u_class_b (.word(b), .op(b_op));

  fp_preadder u_preadder (
    .a_op    (a_op),
    .b_op    (b_op),
    .aligned (aligned)
  );

  fp_mant_adder u_mant_adder (
    .aligned (s1_aligned),
    .norm    (norm)
  );

  fp_round_pack u_round_pack (
    .norm   (s2_norm),
    .result (result)
  );

  //////////////////////////////////////////////////
  // Pipeline registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    s1_aligned <= aligned;
    s2_norm    <= norm;
    sum        <= result;  // Output register
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[1:0], in_valid};
    end
  end

  assign out_valid = valid_q[2];

endmodule

//--- tb/fp_add_tb.sv
`include "fp_add_cfg.svh"

module fp_add_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_DIR  = 28;
  localparam int NUM_RAND = 200;
  localparam int LATENCY  = 3;    // Drive edge to out_valid edge
  localparam int TIMEOUT  = 100;

  typedef struct packed {
    fp_add_pkg::fp_word_t a;
    fp_add_pkg::fp_word_t b;
    fp_add_pkg::fp_word_t sum;
  } vector_s;

  typedef struct packed {
    logic [15:0]          idx;
    logic [31:0]          due;  // Edge count at which out_valid must rise
    fp_add_pkg::fp_word_t a;
    fp_add_pkg::fp_word_t b;
    fp_add_pkg::fp_word_t sum;
  } pending_s;

  //////////////////////////////////////////////////
  // Directed table
  //////////////////////////////////////////////////
  localparam vector_s DIR_TAB [NUM_DIR] = '{
    '{32'h3F80_0000, 32'h3F80_0000, 32'h4000_0000},  // 1 + 1
    '{32'h3F80_0000, 32'h4000_0000, 32'h4040_0000},  // 1 + 2
    '{32'h4040_0000, 32'hBF80_0000, 32'h4000_0000},  // 3 - 1
    '{32'h3FC0_0000, 32'h3E80_0000, 32'h3FE0_0000},  // 1.5 + 0.25
    '{32'h3F80_0000, 32'h3400_0000, 32'h3F80_0001},  // One ulp up
    '{32'h3FFF_FFFF, 32'h3380_0000, 32'h4000_0000},  // Rounding carry
    '{32'h3F80_0000, 32'h3380_0000, 32'h3F80_0000},  // Tie stays even
    '{32'h4B80_0000, 32'h3F80_0000, 32'h4B80_0000},
    '{32'h4B80_0000, 32'h4000_0000, 32'h4B80_0001},
    '{32'h3F80_0000, 32'h2F80_0000, 32'h3F80_0000},  // Shift past the mantissa width
    '{32'h3F80_0000, 32'hBF80_0000, 32'h0000_0000},  // Exact cancellation
    '{32'h3F80_0001, 32'hBF80_0000, 32'h3400_0000},
    '{32'h4000_0000, 32'hBFFF_FFFF, 32'h3400_0000},  // Near equal with a long left shift
    '{32'h0000_0001, 32'h0000_0001, 32'h0000_0002},  // Subnormal pair
    '{32'h0040_0000, 32'h0040_0000, 32'h0080_0000},  // Becomes normal
    '{32'h0080_0000, 32'h0000_0001, 32'h0080_0001},
    '{32'h0080_0000, 32'h8000_0001, 32'h007F_FFFF},  // Drops into subnormal
    '{32'h7FC0_0000, 32'h3F80_0000, `FP_QNAN},
    '{32'h7F80_0001, 32'h0000_0000, `FP_QNAN},       // Signalling NaN in
    '{32'h7F80_0000, 32'hFF80_0000, `FP_QNAN},       // Inf - inf
    '{32'h7F80_0000, 32'hC2C8_0000, 32'h7F80_0000},
    '{32'hFF80_0000, 32'h3F80_0000, 32'hFF80_0000},
    '{32'hFF80_0000, 32'h0000_0000, 32'hFF80_0000},  // Infinity keeps its sign
    '{32'h7F7F_FFFF, 32'h7F7F_FFFF, 32'h7F80_0000},  // Overflow
    '{32'h0000_0000, 32'h0000_0000, 32'h0000_0000},
    '{32'h8000_0000, 32'h8000_0000, 32'h8000_0000},
    '{32'h8000_0000, 32'h0000_0000, 32'h0000_0000},
    '{32'h0000_0000, 32'hC000_0000, 32'hC000_0000}
  };

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 in_valid;
  fp_add_pkg::fp_word_t a;
  fp_add_pkg::fp_word_t b;
  logic                 out_valid;
  fp_add_pkg::fp_word_t sum;

  int       edges = 0;
  int       n_tests = 0;
  int       n_pass = 0;
  int       errors = 0;
  pending_s pend_q[$];

  fp_add_top DUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .sum       (sum)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  always @(posedge clk) edges <= edges + 1;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic real to_real(input fp_add_pkg::fp_word_t w);
    logic [63:0] bits;
    logic [10:0] e;
    e    = 11'(w[30:23]) + 11'd896;  // Rebias 127 to 1023
    bits = {w[31], e, w[22:0], 29'd0};
    return $bitstoreal(bits);
  endfunction

  // Nearest even on the low 29 fraction bits of an exact double
  function automatic fp_add_pkg::fp_word_t to_single(input real r);
    logic [63:0] bits;
    logic [24:0] rnd;
    logic        round_up;
    logic [10:0] e;
    bits = $realtobits(r);
    if (bits[62:0] == 63'd0) begin
      return 32'h0000_0000;
    end
    round_up = bits[28] & ((|bits[27:0]) | bits[29]);
    rnd      = {2'b01, bits[51:29]} + 25'(round_up);
    e        = bits[62:52] - 11'd896;
    if (rnd[24]) begin
      rnd = rnd >> 1;
      e   = e + 11'd1;
    end
    return {bits[63], e[7:0], rnd[22:0]};
  endfunction

  function automatic fp_add_pkg::fp_word_t rand_normal(input int exp_val);
    logic [31:0] r;
    r = $urandom;
    return {r[31], 8'(exp_val), r[22:0]};
  endfunction

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  task automatic check_word(input int idx, input fp_add_pkg::fp_word_t op_a,
                            input fp_add_pkg::fp_word_t op_b,
                            input fp_add_pkg::fp_word_t got,
                            input fp_add_pkg::fp_word_t expected);
    n_tests++;
    if (got !== expected) begin
      errors++;
      $display("MISMATCH at %0t: test %0d %h + %h gave %h, expected %h",
               $time, idx, op_a, op_b, got, expected);
    end else begin
      n_pass++;
      $display("test %0d: %h + %h = %h ok", idx, op_a, op_b, got);
    end
  endtask

  task automatic check_valid(input logic got, input logic expected);
    if (got !== expected) begin
      errors++;
      if (expected) begin
        $display("MISMATCH at %0t: out_valid is %b, a result is due", $time, got);
      end else begin
        $display("MISMATCH at %0t: out_valid is %b with no result due", $time, got);
      end
    end
  endtask

  task automatic drive_pair(input int idx, input vector_s v);
    pending_s p;
    @(posedge clk);
    in_valid <= 1'b1;
    a        <= v.a;
    b        <= v.b;
    p.idx = 16'(idx);
    p.due = 32'(edges + 1 + LATENCY);  // edges still holds the previous count here
    p.a   = v.a;
    p.b   = v.b;
    p.sum = v.sum;
    pend_q.push_back(p);
  endtask

  // Outputs sampled mid-cycle
  always @(negedge clk) begin : monitor
    pending_s p;
    logic     due_now;
    due_now = (pend_q.size() > 0) && (pend_q[0].due == 32'(edges));
    check_valid(out_valid, due_now);
    if (due_now) begin
      p = pend_q.pop_front();
      if (out_valid === 1'b1) begin
        check_word(int'(p.idx), p.a, p.b, sum, p.sum);
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  initial begin
    int      ea;
    int      eb;
    int      wait_cnt;
    vector_s v;
    rst      <= 1'b1;
    in_valid <= 1'b0;
    a        <= '0;
    b        <= '0;
    void'($urandom(32'h2d16_ee19));

    repeat (16) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);

    for (int i = 0; i < NUM_DIR; i++) begin
      drive_pair(i, DIR_TAB[i]);
    end

    // Back-to-back pairs with exponents at most 20 apart keep the double sum exact
    for (int i = 0; i < NUM_RAND; i++) begin
      ea    = 60 + int'($urandom_range(130));
      eb    = ea + int'($urandom_range(40)) - 20;
      v.a   = rand_normal(ea);
      v.b   = rand_normal(eb);
      v.sum = to_single(to_real(v.a) + to_real(v.b));
      drive_pair(NUM_DIR + i, v);
    end

    @(posedge clk);
    in_valid <= 1'b0;

    wait_cnt = 0;
    while (pend_q.size() > 0 && wait_cnt < TIMEOUT) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (pend_q.size() > 0) begin
      errors++;
      $display("Timeout: %0d results never arrived", pend_q.size());
    end
    repeat (2) @(posedge clk);  // out_valid must stay low when idle

    $display("Summary: %0d tests, %0d passed, %0d errors", n_tests, n_pass, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- fp_add.f
+incdir+hdl
hdl/fp_add_pkg.sv
hdl/fp_classify.sv
hdl/fp_preadder.sv
hdl/fp_mant_adder.sv
hdl/fp_round_pack.sv
hdl/fp_add_top.sv
tb/fp_add_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fp_add testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f fp_add.f --top-module fp_add_tb -o sim_fp_add
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_fp_add)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
  exit 0
else
  exit 1
fi
